// File: design/rmt_defines.svh
`ifndef RMT_DEFINES_SVH
`define RMT_DEFINES_SVH

// stream beat geometry
`define RMT_DATA_W       64
`define RMT_KEEP_W       8

// header containers in the first beat
`define RMT_CONT_W       16
`define RMT_CONT_NUM     4

// pipeline sizing
`define RMT_STAGE_NUM    3
`define RMT_TABLE_DEPTH  4
`define RMT_FIFO_DEPTH   16

// container 3 of a control packet carries this
`define RMT_CTRL_MARKER  16'hf1f2

`endif

// File: design/rmt_stream_pkg.sv
`default_nettype none

`include "rmt_defines.svh"

package rmt_stream_pkg;

	// one beat of the 64-bit stream
	typedef struct packed {
		logic [`RMT_DATA_W-1:0] data;
		logic [`RMT_KEEP_W-1:0] keep;
		logic                   last;
	} axis_beat_t;

endpackage

`default_nettype wire

// File: design/rmt_match_pkg.sv
`default_nettype none

`include "rmt_defines.svh"

package rmt_match_pkg;

	// container i sits at data bits 16i+15:16i
	typedef logic [`RMT_CONT_NUM-1:0][`RMT_CONT_W-1:0] phv_t;

	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_SET = 2'd1,
		OP_ADD = 2'd2
	} act_op_e;

	typedef struct packed {
		logic                   valid;
		logic [1:0]             key_sel; // container compared against key_val
		logic [`RMT_CONT_W-1:0] key_val;
		act_op_e                op;
		logic [1:0]             dst_sel; // container the action writes
		logic [`RMT_CONT_W-1:0] operand;
		logic                   pad;
	} table_entry_t;

	// travels down the stage chain, one register per stage
	typedef struct packed {
		logic         strobe;
		logic [2:0]   stage_id;
		logic [1:0]   index;
		table_entry_t entry;
	} cfg_msg_t;

endpackage

`default_nettype wire

// File: design/rmt_sync_fifo.sv
`default_nettype none

module rmt_sync_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 16
) (
	input  wire logic             clk,
	input  wire logic             aresetn,
	input  wire logic             wr_en,
	input  wire logic [WIDTH-1:0] din,
	input  wire logic             rd_en,
	output logic      [WIDTH-1:0] dout,
	output logic                  full,
	output logic                  empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;
	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign dout  = mem[rd_ptr]; // head entry, meaningful while not empty

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/rmt_parser.sv
`default_nettype none

`include "rmt_defines.svh"

module rmt_parser
	import rmt_stream_pkg::*, rmt_match_pkg::*;
(
	input  wire logic clk,
	input  wire logic aresetn,
	input  wire axis_beat_t s_axis,
	input  wire logic s_axis_tvalid,
	input  wire logic s_axis_tready,
	output logic      pkt_wr_en,
	output phv_t      phv_out,
	output logic      phv_valid,
	output cfg_msg_t  cfg_out
);

	logic in_pkt;  // inside a packet, next beat is not a first beat
	logic is_ctrl; // current packet is a control packet
	logic accept;
	logic first_beat;
	logic marker_hit;
	logic ctrl_pkt;

	assign accept     = s_axis_tvalid && s_axis_tready;
	assign first_beat = !in_pkt;
	assign marker_hit = (s_axis.data[`RMT_DATA_W-1 -: `RMT_CONT_W] == `RMT_CTRL_MARKER);
	assign ctrl_pkt   = first_beat ? marker_hit : is_ctrl;
	assign pkt_wr_en  = accept && !ctrl_pkt; // control beats are dropped here

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			in_pkt    <= 1'b0;
			is_ctrl   <= 1'b0;
			phv_valid <= 1'b0;
			cfg_out   <= '0;
		end else begin
			phv_valid      <= accept && first_beat && !marker_hit;
			cfg_out.strobe <= accept && first_beat && marker_hit; // one cycle per control packet
			if (accept && first_beat && marker_hit) begin
				cfg_out.stage_id      <= s_axis.data[47:45];
				cfg_out.index         <= s_axis.data[44:43];
				cfg_out.entry.valid   <= s_axis.data[42];
				cfg_out.entry.key_sel <= s_axis.data[41:40];
				cfg_out.entry.key_val <= s_axis.data[39:24];
				cfg_out.entry.op      <= act_op_e'(s_axis.data[23:22]);
				cfg_out.entry.dst_sel <= s_axis.data[21:20];
				cfg_out.entry.operand <= s_axis.data[19:4];
				cfg_out.entry.pad     <= 1'b0;
			end
			if (accept) begin
				in_pkt <= !s_axis.last;
				if (first_beat)
					is_ctrl <= marker_hit;
			end
		end
	end

	// header containers of a data packet
	always_ff @(posedge clk) begin
		if (accept && first_beat && !marker_hit)
			phv_out <= s_axis.data;
	end

endmodule

`default_nettype wire

// File: design/rmt_stage.sv
`default_nettype none

`include "rmt_defines.svh"

module rmt_stage
	import rmt_match_pkg::*;
#(
	parameter int STAGE_ID = 0
) (
	input  wire logic     clk,
	input  wire logic     aresetn,
	input  wire phv_t     phv_in,
	input  wire logic     phv_in_valid,
	input  wire cfg_msg_t cfg_in,
	output phv_t          phv_out,
	output logic          phv_out_valid,
	output cfg_msg_t      cfg_out
);

	table_entry_t tbl [`RMT_TABLE_DEPTH];
	logic         hit;
	table_entry_t act; // winning entry
	phv_t         phv_next;

	// lowest index wins among valid matching entries
	always_comb begin
		hit = 1'b0;
		act = '0;
		for (int i = 0; i < `RMT_TABLE_DEPTH; i++) begin
			if (!hit && tbl[i].valid && phv_in[tbl[i].key_sel] == tbl[i].key_val) begin
				hit = 1'b1;
				act = tbl[i];
			end
		end
	end

	always_comb begin
		phv_next = phv_in;
		if (hit) begin
			case (act.op)
				OP_SET:  phv_next[act.dst_sel] = act.operand;
				OP_ADD:  phv_next[act.dst_sel] = phv_in[act.dst_sel] + act.operand; // wraps
				default: phv_next = phv_in;
			endcase
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < `RMT_TABLE_DEPTH; i++)
				tbl[i] <= '0;
			phv_out_valid <= 1'b0;
			cfg_out       <= '0;
		end else begin
			if (cfg_in.strobe && cfg_in.stage_id == 3'(STAGE_ID))
				tbl[cfg_in.index] <= cfg_in.entry;
			phv_out_valid <= phv_in_valid;
			cfg_out       <= cfg_in; // forward down the chain
		end
	end

	always_ff @(posedge clk) begin
		if (phv_in_valid)
			phv_out <= phv_next;
	end

endmodule

`default_nettype wire

// File: design/rmt_deparser.sv
`default_nettype none

module rmt_deparser
	import rmt_stream_pkg::*, rmt_match_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       aresetn,
	input  wire axis_beat_t pkt_head,
	input  wire logic       pkt_empty,
	input  wire phv_t       phv_head,
	input  wire logic       phv_empty,
	input  wire logic       m_axis_tready,
	output logic            pkt_rd_en,
	output logic            phv_rd_en,
	output axis_beat_t      m_axis,
	output logic            m_axis_tvalid
);

	typedef enum logic {
		DEP_FIRST,
		DEP_BODY
	} dep_state_e;

	dep_state_e state;
	logic       xfer;

	always_comb begin
		m_axis = pkt_head;
		if (state == DEP_FIRST) begin
			m_axis.data   = phv_head; // header rewritten from the processed PHV
			m_axis_tvalid = !pkt_empty && !phv_empty;
		end else begin
			m_axis_tvalid = !pkt_empty;
		end
	end

	assign xfer      = m_axis_tvalid && m_axis_tready;
	assign pkt_rd_en = xfer;
	assign phv_rd_en = xfer && (state == DEP_FIRST); // one PHV per packet

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			state <= DEP_FIRST;
		else if (xfer)
			state <= pkt_head.last ? DEP_FIRST : DEP_BODY;
	end

endmodule

`default_nettype wire

// File: design/rmt_top.sv
`default_nettype none

`include "rmt_defines.svh"

module rmt_top
	import rmt_stream_pkg::*, rmt_match_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       aresetn,
	input  wire axis_beat_t s_axis,
	input  wire logic       s_axis_tvalid,
	output logic            s_axis_tready,
	output axis_beat_t      m_axis,
	output logic            m_axis_tvalid,
	input  wire logic       m_axis_tready
);

	logic       pkt_wr_en;
	logic       pkt_rd_en;
	logic       pkt_full;
	logic       pkt_empty;
	axis_beat_t pkt_head;

	logic phv_rd_en;
	logic phv_empty;
	phv_t phv_head;

	// index 0 is the parser output, index k+1 is stage k output
	phv_t     stg_phv   [`RMT_STAGE_NUM+1];
	logic     stg_valid [`RMT_STAGE_NUM+1];
	cfg_msg_t stg_cfg   [`RMT_STAGE_NUM+1];

	assign s_axis_tready = !pkt_full;

	rmt_parser u_parser (
		.clk           (clk),
		.aresetn       (aresetn),
		.s_axis        (s_axis),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.pkt_wr_en     (pkt_wr_en),
		.phv_out       (stg_phv[0]),
		.phv_valid     (stg_valid[0]),
		.cfg_out       (stg_cfg[0])
	);

	rmt_sync_fifo #(.WIDTH($bits(axis_beat_t)), .DEPTH(`RMT_FIFO_DEPTH)) u_pkt_fifo (
		.clk     (clk),
		.aresetn (aresetn),
		.wr_en   (pkt_wr_en),
		.din     (s_axis),
		.rd_en   (pkt_rd_en),
		.dout    (pkt_head),
		.full    (pkt_full),
		.empty   (pkt_empty)
	);

	for (genvar k = 0; k < `RMT_STAGE_NUM; k++) begin : g_stage
		rmt_stage #(.STAGE_ID(k)) u_stage (
			.clk           (clk),
			.aresetn       (aresetn),
			.phv_in        (stg_phv[k]),
			.phv_in_valid  (stg_valid[k]),
			.cfg_in        (stg_cfg[k]),
			.phv_out       (stg_phv[k+1]),
			.phv_out_valid (stg_valid[k+1]),
			.cfg_out       (stg_cfg[k+1])
		);
	end

	// sized like the packet FIFO, so it never fills first
	rmt_sync_fifo #(.WIDTH($bits(phv_t)), .DEPTH(`RMT_FIFO_DEPTH)) u_phv_fifo (
		.clk     (clk),
		.aresetn (aresetn),
		.wr_en   (stg_valid[`RMT_STAGE_NUM]),
		.din     (stg_phv[`RMT_STAGE_NUM]),
		.rd_en   (phv_rd_en),
		.dout    (phv_head),
		.full    (),
		.empty   (phv_empty)
	);

	rmt_deparser u_deparser (
		.clk           (clk),
		.aresetn       (aresetn),
		.pkt_head      (pkt_head),
		.pkt_empty     (pkt_empty),
		.phv_head      (phv_head),
		.phv_empty     (phv_empty),
		.m_axis_tready (m_axis_tready),
		.pkt_rd_en     (pkt_rd_en),
		.phv_rd_en     (phv_rd_en),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid)
	);

endmodule

`default_nettype wire

// File: verification/rmt_tb.sv
`default_nettype none

`include "rmt_defines.svh"

module rmt_tb
	import rmt_stream_pkg::*, rmt_match_pkg::*;
();

	// ~60 data packets of up to 4 beats, halved rate under back-pressure, idle gaps
	// after 8 control packets: about 1000 cycles, limit leaves a wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic       clk;
	logic       aresetn;
	axis_beat_t s_axis;
	logic       s_axis_tvalid;
	logic       s_axis_tready;
	axis_beat_t m_axis;
	logic       m_axis_tvalid;
	logic       m_axis_tready;

	table_entry_t mirror [`RMT_STAGE_NUM][`RMT_TABLE_DEPTH]; // tables as loaded so far
	axis_beat_t   exp_q [$];
	axis_beat_t   mon_exp;
	int           errors;
	int           beats_seen;
	int           stalls; // cycles an input beat waited on s_axis_tready
	int           cycles;
	string        cur_test;
	logic [31:0]  rnd_state;
	logic [31:0]  bp_state;
	logic         bp_en;
	logic         bp_now; // bp_en as seen at the edge

	rmt_top DUT (
		.clk           (clk),
		.aresetn       (aresetn),
		.s_axis        (s_axis),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand32();
		rnd_state = xorshift(rnd_state);
		return rnd_state;
	endfunction

	// random first beat that is never taken for a control packet
	function automatic logic [63:0] rand_first();
		logic [63:0] d;
		d = {rand32(), rand32()};
		if (d[63:48] == `RMT_CTRL_MARKER)
			d[63:48] = ~d[63:48];
		return d;
	endfunction

	// stage rule applied stage after stage on the mirrored tables
	function automatic logic [63:0] model_phv(input logic [63:0] d);
		logic [15:0]  c [4];
		table_entry_t e;
		logic         hit;
		for (int k = 0; k < 4; k++)
			c[k] = d[16*k +: 16];
		for (int s = 0; s < `RMT_STAGE_NUM; s++) begin
			hit = 1'b0;
			for (int i = 0; i < `RMT_TABLE_DEPTH; i++) begin
				e = mirror[s][i];
				if (!hit && e.valid && c[e.key_sel] == e.key_val) begin
					hit = 1'b1; // first match in index order
					if (e.op == OP_SET)
						c[e.dst_sel] = e.operand;
					else if (e.op == OP_ADD)
						c[e.dst_sel] = c[e.dst_sel] + e.operand;
				end
			end
		end
		return {c[3], c[2], c[1], c[0]};
	endfunction

	task automatic check_model(input logic [63:0] d, input logic [63:0] want);
		if (model_phv(d) !== want) begin
			errors++;
			$display("[ERROR] %s: header expected %h, actual %h", cur_test, want, model_phv(d));
		end
	endtask

	// runs from edge+5 to edge+5
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#5;
		end
	endtask

	task automatic send_beat(input axis_beat_t b);
		logic done;
		s_axis        = b;
		s_axis_tvalid = 1'b1;
		done          = 1'b0;
		while (!done) begin
			done = s_axis_tready; // stable until the next edge
			if (!done)
				stalls++;
			@(posedge clk);
			#5;
		end
		s_axis_tvalid = 1'b0;
	endtask

	task automatic send_data(input int nbeats, input logic [63:0] first);
		axis_beat_t  b;
		axis_beat_t  exp_b;
		logic [31:0] r;
		for (int n = 0; n < nbeats; n++) begin
			r      = rand32();
			b.data = (n == 0) ? first : {rand32(), rand32()};
			b.last = (n == nbeats - 1);
			b.keep = b.last ? (8'hff >> r[2:0]) : 8'hff;
			exp_b  = b;
			if (n == 0)
				exp_b.data = model_phv(first); // only the header beat changes
			exp_q.push_back(exp_b);
			send_beat(b);
		end
	endtask

	task automatic send_ctrl(input int stage, input int idx, input logic vld,
			input logic [1:0] ksel, input logic [15:0] kval, input logic [1:0] op,
			input logic [1:0] dsel, input logic [15:0] operand, input int nbeats);
		axis_beat_t b;
		b.data = {`RMT_CTRL_MARKER, 3'(stage), 2'(idx), vld, ksel, kval, op, dsel,
			operand, 4'h0};
		for (int n = 0; n < nbeats; n++) begin
			if (n > 0)
				b.data = {rand32(), rand32()};
			b.keep = 8'hff;
			b.last = (n == nbeats - 1);
			send_beat(b);
		end
		mirror[stage][idx] = '{valid: vld, key_sel: ksel, key_val: kval,
			op: act_op_e'(op), dst_sel: dsel, operand: operand, pad: 1'b0};
		idle(10); // config settles before the next data packet
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			idle(1);
		idle(4); // room for a stray beat to show up
	endtask

	task automatic report_test(input int e0);
		$display("%s: done, %0d errors", cur_test, errors - e0);
	endtask

	task automatic pass_through_test();
		int e0;
		e0       = errors;
		cur_test = "pass_through";
		repeat (8)
			send_data((rand32() % 4) + 1, rand_first());
		wait_drain();
		report_test(e0);
	endtask

	task automatic set_action_test();
		int          e0;
		logic [63:0] d;
		e0       = errors;
		cur_test = "set_action";
		send_ctrl(0, 0, 1'b1, 2'd0, 16'haaaa, OP_SET, 2'd2, 16'h5555, 1);
		check_model(64'h1234_0000_5678_aaaa, 64'h1234_5555_5678_aaaa);
		for (int i = 0; i < 6; i++) begin
			d = rand_first();
			if (i % 2 == 0)
				d[15:0] = 16'haaaa; // hit on container 0
			send_data((rand32() % 4) + 1, d);
		end
		wait_drain();
		report_test(e0);
	endtask

	task automatic chain_test();
		int e0;
		e0       = errors;
		cur_test = "chain_priority";
		send_ctrl(0, 0, 1'b1, 2'd0, 16'h1000, OP_ADD, 2'd1, 16'h0234, 1);
		send_ctrl(1, 0, 1'b1, 2'd1, 16'h2234, OP_SET, 2'd2, 16'hbeef, 2);
		send_ctrl(2, 1, 1'b1, 2'd0, 16'h1000, OP_SET, 2'd3, 16'h1111, 1);
		send_ctrl(2, 2, 1'b1, 2'd0, 16'h1000, OP_SET, 2'd3, 16'h2222, 3);
		send_ctrl(0, 1, 1'b1, 2'd0, 16'h3000, OP_ADD, 2'd2, 16'hfff0, 1);
		// stage 1 keys on the stage 0 sum, stage 2 index 1 beats index 2
		check_model(64'h0000_0000_2000_1000, 64'h1111_beef_2234_1000);
		check_model(64'h0000_0020_0000_3000, 64'h0000_0010_0000_3000); // wraps
		send_data(2, 64'h0000_0000_2000_1000);
		send_data(1, 64'h0000_0020_0000_3000);
		send_data(3, 64'h4444_0020_0000_3000);
		wait_drain();
		report_test(e0);
	endtask

	task automatic ctrl_test();
		int e0;
		e0       = errors;
		cur_test = "control_packets";
		send_ctrl(2, 0, 1'b1, 2'd0, 16'h7777, OP_SET, 2'd1, 16'h0abc, 4);
		check_model(64'h1234_5678_9abc_7777, 64'h1234_5678_0abc_7777);
		send_data(3, 64'h1234_5678_9abc_7777);
		send_ctrl(2, 0, 1'b0, 2'd0, 16'h7777, OP_SET, 2'd1, 16'h0abc, 3);
		check_model(64'h1234_5678_9abc_7777, 64'h1234_5678_9abc_7777);
		send_data(2, 64'h1234_5678_9abc_7777);
		wait_drain();
		report_test(e0);
	endtask

	task automatic backpressure_test();
		int e0;
		int s0;
		e0       = errors;
		s0       = stalls;
		cur_test = "back_pressure";
		bp_en    = 1'b1;
		repeat (40)
			send_data((rand32() % 4) + 1, rand_first());
		wait_drain();
		bp_en = 1'b0;
		if (stalls == s0) begin
			errors++;
			$display("%s: s_axis_tready never fell, the packet FIFO did not fill", cur_test);
		end
		report_test(e0);
	endtask

	// output ready, toggled only while back-pressure is on
	always @(posedge clk) begin
		bp_now = bp_en;
		#5;
		if (bp_now) begin
			bp_state      = xorshift(bp_state);
			m_axis_tready = bp_state[0];
		end else begin
			m_axis_tready = 1'b1;
		end
	end

	// a transfer seen here completes on the next rising edge
	always @(negedge clk) begin
		if (aresetn && m_axis_tvalid && m_axis_tready) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: output beat %h arrived with no packet pending", cur_test, m_axis);
			end else begin
				mon_exp = exp_q.pop_front();
				beats_seen++;
				if (m_axis !== mon_exp) begin
					errors++;
					$display("[ERROR] %s: expected %h, actual %h", cur_test, mon_exp, m_axis);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, output stopped or never drained", cycles);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		aresetn       = 1'b0;
		s_axis        = '0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		bp_en         = 1'b0;
		errors        = 0;
		beats_seen    = 0;
		stalls        = 0;
		cycles        = 0;
		cur_test      = "reset";
		rnd_state     = 32'hb280_92c6;
		bp_state      = ~32'hb280_92c6;
		for (int s = 0; s < `RMT_STAGE_NUM; s++)
			for (int i = 0; i < `RMT_TABLE_DEPTH; i++)
				mirror[s][i] = '0;
		repeat (10) @(posedge clk);
		#5;
		aresetn = 1'b1;
		idle(2);

		pass_through_test();
		set_action_test();
		chain_test();
		ctrl_test();
		backpressure_test();

		$display("summary: %0d beats compared, %0d errors", beats_seen, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/rmt_stream_pkg.sv
design/rmt_match_pkg.sv
design/rmt_sync_fifo.sv
design/rmt_parser.sv
design/rmt_stage.sv
design/rmt_deparser.sv
design/rmt_top.sv
verification/rmt_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module rmt_tb -Mdir obj_dir -o rmt_sim
if [ $? -ne 0 ]; then
	echo "verilator build did not complete"
	exit 1
fi

./obj_dir/rmt_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
